// File: hdl/decodePkg.sv
package decodePkg;

  typedef logic [7:0] opByte_t;
  typedef logic [2:0] regField_t; // ModRM bits 5:3.

  localparam int NumRows = 24;
  localparam int NumGroupOpcodes = 10;

  typedef struct packed {
    opByte_t   opcode;
    logic      regMatch; // Row also needs the ModRM reg field.
    regField_t regVal;
  } pattern_t;

  // One row per distinct pattern. The row number is the control store address.
  localparam pattern_t PatternTable [NumRows] = '{
    '{8'h04, 1'b0, 3'd0}, '{8'h05, 1'b0, 3'd0},
    '{8'h80, 1'b1, 3'd0}, '{8'h81, 1'b1, 3'd0},
    '{8'h83, 1'b1, 3'd0}, '{8'h00, 1'b0, 3'd0},
    '{8'h01, 1'b0, 3'd0}, '{8'h02, 1'b0, 3'd0},
    '{8'h03, 1'b0, 3'd0}, '{8'h24, 1'b0, 3'd0},
    '{8'h25, 1'b0, 3'd0}, '{8'h80, 1'b1, 3'd4},
    '{8'h20, 1'b0, 3'd0}, '{8'h21, 1'b0, 3'd0},
    '{8'hFF, 1'b1, 3'd2}, '{8'hFF, 1'b1, 3'd4},
    '{8'h88, 1'b0, 3'd0}, '{8'h89, 1'b0, 3'd0},
    '{8'hB0, 1'b0, 3'd0}, '{8'hC3, 1'b0, 3'd0},
    '{8'hC2, 1'b0, 3'd0}, '{8'hD0, 1'b1, 3'd4},
    '{8'hC1, 1'b1, 3'd7}, '{8'h90, 1'b0, 3'd0}
  };

  // Opcodes followed by a ModRM byte whose reg field picks the operation.
  localparam opByte_t GroupOpcodes [NumGroupOpcodes] = '{
    8'h80, 8'h81, 8'h83, 8'hC0, 8'hC1,
    8'hD0, 8'hD1, 8'hD2, 8'hD3, 8'hFF
  };

endpackage

// File: hdl/ucodePkg.sv
package ucodePkg;

  // Control store address with one entry per pattern row.
  typedef logic [$clog2(decodePkg::NumRows)-1:0] rowIdx_t;

  typedef logic [31:0] ctrlWord_t; // Microcode word.

  localparam int DefaultCountWidth = 16;

endpackage

// File: hdl/decodeIf.sv
interface decodeIf;

  logic                valid;    // One-cycle request strobe.
  decodePkg::opByte_t   opcode;
  decodePkg::regField_t regField;
  logic                hasModrm;

  modport source (
    output valid, opcode, regField, hasModrm
  );

  modport sink (
    input valid, opcode, regField, hasModrm
  );

endinterface

// File: hdl/opcodeFetch.sv
module opcodeFetch (
  input  logic               clk,
  input  logic               arstN,
  input  logic               byteValid,
  input  decodePkg::opByte_t byteIn,
  decodeIf.source            req
);

  typedef enum logic {
    waitOpcode,
    waitModrm
  } fetchState_t;

  fetchState_t        state;
  decodePkg::opByte_t pendingOp; // Group opcode waiting for its ModRM.
  logic               isGroup;

  always_comb begin
    isGroup = 1'b0;
    for (int i = 0; i < decodePkg::NumGroupOpcodes; i++) begin
      if (byteIn == decodePkg::GroupOpcodes[i]) isGroup = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state     <= waitOpcode;
      req.valid <= 1'b0;
    end else begin
      req.valid <= 1'b0;
      if (byteValid) begin
        if (state == waitModrm) begin
          req.valid <= 1'b1;
          state     <= waitOpcode;
        end else if (isGroup) begin
          state <= waitModrm;
        end else begin
          req.valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byteValid) begin
      if (state == waitModrm) begin
        req.opcode   <= pendingOp;
        req.regField <= byteIn[5:3];
        req.hasModrm <= 1'b1;
      end else begin
        pendingOp    <= byteIn;
        req.opcode   <= byteIn;
        req.regField <= '0;
        req.hasModrm <= 1'b0;
      end
    end
  end

endmodule

// File: hdl/opcodeMatch.sv
module opcodeMatch (
  decodeIf.sink              req,
  output logic               reqValid,
  output logic               hit,
  output ucodePkg::rowIdx_t  row
);

  logic [decodePkg::NumRows-1:0] rowEq;

  // One comparator per pattern row.
  always_comb begin
    for (int i = 0; i < decodePkg::NumRows; i++) begin
      rowEq[i] = (req.opcode == decodePkg::PatternTable[i].opcode) &&
                 (!decodePkg::PatternTable[i].regMatch ||
                  (req.hasModrm &&
                   req.regField == decodePkg::PatternTable[i].regVal));
    end
  end

  // Priority select where the lowest row wins.
  always_comb begin
    hit = 1'b0;
    row = '0;
    for (int i = decodePkg::NumRows - 1; i >= 0; i--) begin
      if (rowEq[i]) begin
        hit = 1'b1;
        row = ucodePkg::rowIdx_t'(i);
      end
    end
  end

  assign reqValid = req.valid;

endmodule

// File: hdl/controlStore.sv
module controlStore (
  input  logic                clk,
  input  logic                arstN,
  input  logic                reqValid,
  input  logic                hit,
  input  ucodePkg::rowIdx_t   row,
  input  logic                csWrite,
  input  ucodePkg::rowIdx_t   csAddr,
  input  ucodePkg::ctrlWord_t csData,
  output logic                wordValid,
  output logic                wordHit,
  output ucodePkg::ctrlWord_t word
);

  ucodePkg::ctrlWord_t mem [decodePkg::NumRows];

  always_ff @(posedge clk) begin
    if (csWrite && int'(csAddr) < decodePkg::NumRows) mem[csAddr] <= csData;
    if (reqValid) word <= mem[row]; // Row is 0 on a miss.
  end

  // Flags line up with the read data.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wordValid <= 1'b0;
      wordHit   <= 1'b0;
    end else begin
      wordValid <= reqValid;
      wordHit   <= hit;
    end
  end

endmodule

// File: hdl/microWordOut.sv
module microWordOut #(
  parameter int CountWidth = ucodePkg::DefaultCountWidth
) (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  wordValid,
  input  logic                  wordHit,
  input  ucodePkg::ctrlWord_t   word,
  output logic                  microValid,
  output logic                  illegal,
  output ucodePkg::ctrlWord_t   microWord,
  output logic [CountWidth-1:0] decodedCount
);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      microValid   <= 1'b0;
      illegal      <= 1'b0;
      decodedCount <= '0;
    end else begin
      microValid <= wordValid && wordHit;
      illegal    <= wordValid && !wordHit;
      if (wordValid) decodedCount <= decodedCount + 1'b1; // Wraps.
    end
  end

  // Holds the last good word across misses.
  always_ff @(posedge clk) begin
    if (wordValid && wordHit) microWord <= word;
  end

endmodule

// File: hdl/csDecoder.sv
module csDecoder #(
  parameter int CountWidth = ucodePkg::DefaultCountWidth
) (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  byteValid,
  input  decodePkg::opByte_t    byteIn,
  input  logic                  csWrite,
  input  ucodePkg::rowIdx_t     csAddr,
  input  ucodePkg::ctrlWord_t   csData,
  output logic                  microValid,
  output ucodePkg::ctrlWord_t   microWord,
  output logic                  illegal,
  output logic [CountWidth-1:0] decodedCount
);

  decodeIf decReq ();

  logic                reqValid;
  logic                hit;
  ucodePkg::rowIdx_t   row;
  logic                wordValid;
  logic                wordHit;
  ucodePkg::ctrlWord_t word;

  opcodeFetch fetch (
    .clk       (clk),
    .arstN     (arstN),
    .byteValid (byteValid),
    .byteIn    (byteIn),
    .req       (decReq.source)
  );

  opcodeMatch match (
    .req      (decReq.sink),
    .reqValid (reqValid),
    .hit      (hit),
    .row      (row)
  );

  controlStore store (
    .clk       (clk),
    .arstN     (arstN),
    .reqValid  (reqValid),
    .hit       (hit),
    .row       (row),
    .csWrite   (csWrite),
    .csAddr    (csAddr),
    .csData    (csData),
    .wordValid (wordValid),
    .wordHit   (wordHit),
    .word      (word)
  );

  microWordOut #(
    .CountWidth (CountWidth)
  ) outReg (
    .clk          (clk),
    .arstN        (arstN),
    .wordValid    (wordValid),
    .wordHit      (wordHit),
    .word         (word),
    .microValid   (microValid),
    .illegal      (illegal),
    .microWord    (microWord),
    .decodedCount (decodedCount)
  );

endmodule

// File: bench/clockGen.sv
module clockGen #(
  parameter int HalfPeriod  = 20,
  parameter int ResetCycles = 2
) (
  output logic clk,
  output logic arstN
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(HalfPeriod) clk = ~clk;
  end

  // Release just after an edge, like the rest of the stimulus.
  initial begin
    arstN = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #5 arstN = 1'b1;
  end

endmodule

// File: bench/csDecoder_properties.sv
module csDecoderProperties #(
  parameter int CountWidth = 16
) (
  input logic                  clk,
  input logic                  arstN,
  input logic                  wordValid,
  input logic                  microValid,
  input logic                  illegal,
  input logic [CountWidth-1:0] decodedCount
);
  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0; // Assertion failures so far.

  // A result is either a word or an illegal opcode, never both.
  notBothHigh: assert property (
    @(posedge clk) disable iff (!arstN) !(microValid && illegal)
  ) else begin
    failCount++;
    $error("microValid and illegal are high in the same cycle");
  end

  quietInReset: assert property (
    @(posedge clk) !arstN |=> !microValid && !illegal
  ) else begin
    failCount++;
    $error("result strobe is high during reset");
  end

  countAfterWord: assert property (
    @(posedge clk) disable iff (!arstN) $changed(decodedCount) |-> $past(wordValid)
  ) else begin
    failCount++;
    $error("decodedCount changed without a valid word one cycle before");
  end

endmodule

bind microWordOut csDecoderProperties #(
  .CountWidth (CountWidth)
) props (
  .clk          (clk),
  .arstN        (arstN),
  .wordValid    (wordValid),
  .microValid   (microValid),
  .illegal      (illegal),
  .decodedCount (decodedCount)
);

// File: bench/csDecoderTb.sv
module csDecoderTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CountWidth = ucodePkg::DefaultCountWidth;
  localparam int RandCycles = 200;
  localparam int DirectedCycles = 60; // Reset, directed bytes and idle gaps.
  localparam int TimeoutCycles = decodePkg::NumRows + 1 + DirectedCycles + RandCycles + 50;

  typedef logic [CountWidth-1:0] count_t;

  logic                clk;
  logic                arstN;
  logic                byteValid;
  decodePkg::opByte_t  byteIn;
  logic                csWrite;
  ucodePkg::rowIdx_t   csAddr;
  ucodePkg::ctrlWord_t csData;
  logic                microValid;
  ucodePkg::ctrlWord_t microWord;
  logic                illegal;
  count_t              decodedCount;

  int                  seed = 32'ha138_a7ad;
  int                  cycleCount = 0;
  int                  instCount = 0;
  ucodePkg::ctrlWord_t refMem [decodePkg::NumRows]; // Words written to the control store.
  bit                  refWaitModrm = 1'b0;
  decodePkg::opByte_t  refPendingOp;
  bit                  expValidQ [$];
  bit                  expHitQ [$];
  ucodePkg::ctrlWord_t expWordQ [$];
  ucodePkg::ctrlWord_t lastWord;
  bit                  haveWord = 1'b0;

  clockGen clkGen (
    .clk   (clk),
    .arstN (arstN)
  );

  csDecoder #(
    .CountWidth (CountWidth)
  ) UUT (
    .clk          (clk),
    .arstN        (arstN),
    .byteValid    (byteValid),
    .byteIn       (byteIn),
    .csWrite      (csWrite),
    .csAddr       (csAddr),
    .csData       (csData),
    .microValid   (microValid),
    .microWord    (microWord),
    .illegal      (illegal),
    .decodedCount (decodedCount)
  );

  function automatic bit isGroupOp(input decodePkg::opByte_t op);
    return op inside {8'h80, 8'h81, 8'h83, 8'hC0, 8'hC1, [8'hD0:8'hD3], 8'hFF};
  endfunction

  // The first table row that fits wins and gives the word last written there.
  function automatic bit refLookup(
    input  decodePkg::opByte_t   op,
    input  bit                   hasModrm,
    input  decodePkg::regField_t regField,
    output ucodePkg::rowIdx_t    row,
    output ucodePkg::ctrlWord_t  word
  );
    bit found;
    found = 1'b0;
    row = '0;
    for (int i = 0; i < decodePkg::NumRows; i++) begin
      if (!found && op == decodePkg::PatternTable[i].opcode &&
          (!decodePkg::PatternTable[i].regMatch ||
           (hasModrm && regField == decodePkg::PatternTable[i].regVal))) begin
        found = 1'b1;
        row = ucodePkg::rowIdx_t'(i);
      end
    end
    word = found ? refMem[row] : '0;
    return found;
  endfunction

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp)
      reportFailure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic checkWord(input string name, input ucodePkg::ctrlWord_t got,
                           input ucodePkg::ctrlWord_t exp);
    if (got !== exp)
      reportFailure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic checkCount(input string name, input count_t got, input count_t exp);
    if (got !== exp)
      reportFailure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #5;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) nextCycle();
  endtask

  task automatic sendByte(input decodePkg::opByte_t b);
    byteValid = 1'b1;
    byteIn    = b;
    nextCycle();
    byteValid = 1'b0;
  endtask

  task automatic writeRow(input ucodePkg::rowIdx_t addr, input ucodePkg::ctrlWord_t data);
    csWrite     = 1'b1;
    csAddr      = addr;
    csData      = data;
    refMem[addr] = data;
    nextCycle();
    csWrite = 1'b0;
  endtask

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > TimeoutCycles)
      reportFailure("timeout: the run did not finish within the cycle limit");
  end

  // Expected result of the instruction completed at this edge.
  always @(posedge clk) begin
    bit                  valid;
    bit                  hitNow;
    ucodePkg::rowIdx_t   row;
    ucodePkg::ctrlWord_t word;
    if (arstN) begin
      valid  = 1'b0;
      hitNow = 1'b0;
      word   = '0;
      if (byteValid) begin
        if (refWaitModrm) begin
          hitNow       = refLookup(refPendingOp, 1'b1, byteIn[5:3], row, word);
          valid        = 1'b1;
          refWaitModrm = 1'b0;
        end else if (isGroupOp(byteIn)) begin
          refPendingOp = byteIn;
          refWaitModrm = 1'b1;
        end else begin
          hitNow = refLookup(byteIn, 1'b0, '0, row, word);
          valid  = 1'b1;
        end
      end
      expValidQ.push_back(valid);
      expHitQ.push_back(hitNow);
      expWordQ.push_back(word);
      if (valid) instCount++;
    end
  end

  // Entries are two edges old when popped, which is the pipeline depth.
  always @(negedge clk) begin
    bit                  valid;
    bit                  hitNow;
    ucodePkg::ctrlWord_t word;
    if (arstN && expValidQ.size() > 2) begin
      valid  = expValidQ.pop_front();
      hitNow = expHitQ.pop_front();
      word   = expWordQ.pop_front();
      checkFlag("microValid", microValid, valid && hitNow);
      checkFlag("illegal", illegal, valid && !hitNow);
      if (valid && hitNow) begin
        lastWord = word;
        haveWord = 1'b1;
      end
      if (haveWord) checkWord("microWord", microWord, lastWord);
    end
  end

  initial begin
    decodePkg::opByte_t   grpOps [12];
    decodePkg::regField_t grpRegs [12];
    decodePkg::opByte_t   b;
    ucodePkg::rowIdx_t    r;
    ucodePkg::ctrlWord_t  w;
    grpOps  = '{8'h80, 8'h80, 8'h81, 8'h83, 8'hFF, 8'hFF,
                8'hD0, 8'hC1, 8'h80, 8'hC0, 8'hD3, 8'hFF};
    grpRegs = '{3'd0, 3'd4, 3'd0, 3'd0, 3'd2, 3'd4,
                3'd4, 3'd7, 3'd1, 3'd0, 3'd5, 3'd7}; // Last four have no row.
    byteValid = 1'b0;
    byteIn    = '0;
    csWrite   = 1'b0;
    csAddr    = '0;
    csData    = '0;
    @(posedge arstN);
    checkFlag("microValid", microValid, 1'b0);
    checkFlag("illegal", illegal, 1'b0);
    checkCount("decodedCount", decodedCount, '0);
    for (int i = 0; i < decodePkg::NumRows; i++) writeRow(ucodePkg::rowIdx_t'(i), $random(seed));
    for (int i = 0; i < decodePkg::NumRows; i++) begin
      if (!decodePkg::PatternTable[i].regMatch) sendByte(decodePkg::PatternTable[i].opcode);
    end
    idle(2);
    for (int i = 0; i < 12; i++) begin
      sendByte(grpOps[i]);
      sendByte({2'b11, grpRegs[i], 3'b000});
    end
    idle(2);
    repeat (RandCycles) begin
      if (($random(seed) & 3) == 0) begin
        idle(1);
      end else begin
        if ($random(seed) & 1)
          b = decodePkg::PatternTable[($random(seed) & 32'h7fff) % decodePkg::NumRows].opcode;
        else
          b = $random(seed);
        sendByte(b);
      end
    end
    if (refWaitModrm) sendByte(8'h00); // Complete a pending group opcode.
    idle(2);
    void'(refLookup(8'h88, 1'b0, '0, r, w));
    writeRow(r, $random(seed));
    sendByte(8'h88);
    sendByte(8'h89);
    sendByte(8'h88);
    idle(4);
    checkCount("decodedCount", decodedCount, count_t'(instCount));
    if (UUT.outReg.props.failCount == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      reportFailure("concurrent assertions failed during the run");
    end
  end

endmodule

// File: csDecoder.f
hdl/decodePkg.sv
hdl/ucodePkg.sv
hdl/decodeIf.sv
hdl/opcodeFetch.sv
hdl/opcodeMatch.sv
hdl/controlStore.sv
hdl/microWordOut.sv
hdl/csDecoder.sv
bench/clockGen.sv
bench/csDecoder_properties.sv
bench/csDecoderTb.sv

// File: Bender.yml
package:
  name: csDecoder

dependencies: {}

sources:
  - target: rtl
    files:
      - hdl/decodePkg.sv
      - hdl/ucodePkg.sv
      - hdl/decodeIf.sv
      - hdl/opcodeFetch.sv
      - hdl/opcodeMatch.sv
      - hdl/controlStore.sv
      - hdl/microWordOut.sv
      - hdl/csDecoder.sv

  - target: test
    files:
      - bench/clockGen.sv
      - bench/csDecoder_properties.sv
      - bench/csDecoderTb.sv
